//--- Bender.yml
package:
  name: out_port_allocator

sources:
  - include_dirs:
      - hw
    files:
      - hw/routerArbPkg.sv
      - hw/portTimerBank.sv
      - hw/grantFsm.sv
      - hw/flitSwitch.sv
      - hw/outPortAllocator.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/outPortAllocator_chk.sv
      - tb/outPortAllocatorTb.sv

//--- hw/flitSwitch.sv
`timescale 1ns/1ps
`default_nettype none
`include "routerArb_macros.svh"

module flitSwitch (
  input  wire logic                                   clk,
  input  wire logic                                   rst,
  input  wire routerArbPkg::grantState_t              state,
  input  wire routerArbPkg::portIn_t [`NUM_PORTS-1:0] ports,
  output routerArbPkg::portMask_t                     grant,
  output logic                                        outValid,
  output routerArbPkg::flitOut_t                      outFlit
);

  routerArbPkg::portMask_t selMask;
  int                      selIdx;

  assign selMask = state[`NUM_PORTS:1]; // all zero while idle.

  always_comb
  begin
    selIdx = 0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (selMask[p])
        selIdx = p;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant    <= '0;
      outValid <= 1'b0;
    end
    else
    begin
      grant    <= selMask;
      outValid <= (|selMask) && ports[selIdx].req;
    end
  end

  // the last forwarded flit stays on the output while no port is granted.
  always_ff @(posedge clk)
  begin
    if (|selMask)
    begin
      outFlit <= '{flitId: ports[selIdx].flitId, payload: ports[selIdx].payload};
    end
  end

endmodule

`default_nettype wire

//--- hw/grantFsm.sv
`timescale 1ns/1ps
`default_nettype none
`include "routerArb_macros.svh"

module grantFsm (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire routerArbPkg::portMask_t req,
  input  wire routerArbPkg::portMask_t timesUp,
  output routerArbPkg::grantState_t    state,
  output routerArbPkg::portMask_t      runTimer
);

  routerArbPkg::grantState_t nextState;
  routerArbPkg::portMask_t   holdMask;
  routerArbPkg::portMask_t   pickMask;
  int                        holder;
  int                        scanStart;

  assign holdMask = state[`NUM_PORTS:1];

  // decode the holding port and the place where the next search begins.
  always_comb
  begin
    holder    = 0;
    scanStart = 0; // from idle, Local is looked at first.
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (holdMask[p])
      begin
        holder    = p;
        scanStart = p + 1;
      end
    end
  end

  // pick the first requesting port in cyclic order with the holder itself last.
  always_comb
  begin
    int idx;
    pickMask = '0;
    for (int k = 0; k < `NUM_PORTS; k++)
    begin
      idx = scanStart + k;
      if (idx >= `NUM_PORTS)
        idx = idx - `NUM_PORTS;
      if ((pickMask == '0) && req[idx])
        pickMask[idx] = 1'b1;
    end
  end

  always_comb
  begin
    nextState = routerArbPkg::IDLE;
    runTimer  = '0;
    case (state)
      routerArbPkg::IDLE:
      begin
        nextState = routerArbPkg::grantState_t'({pickMask, ~|pickMask});
      end
      routerArbPkg::GRANT_L,
      routerArbPkg::GRANT_N,
      routerArbPkg::GRANT_E,
      routerArbPkg::GRANT_W,
      routerArbPkg::GRANT_S:
      begin
        if (req[holder] && !timesUp[holder])
        begin
          runTimer[holder] = 1'b1; // hold and keep counting.
          nextState        = state;
        end
        else
        begin
          // an empty pick leaves only the idle bit set.
          nextState = routerArbPkg::grantState_t'({pickMask, ~|pickMask});
        end
      end
      default:
      begin
        nextState = routerArbPkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= routerArbPkg::IDLE;
    else
      state <= nextState;
  end

endmodule

`default_nettype wire

//--- hw/outPortAllocator.sv
`timescale 1ns/1ps
`default_nettype none
`include "routerArb_macros.svh"

module outPortAllocator (
  input  wire logic                                   clk,
  input  wire logic                                   rst,
  input  wire routerArbPkg::portIn_t [`NUM_PORTS-1:0] ports,
  output routerArbPkg::portMask_t                     grant,
  output logic                                        outValid,
  output routerArbPkg::flitOut_t                      outFlit
);

  routerArbPkg::portMask_t   req;
  routerArbPkg::portMask_t   runTimer;
  routerArbPkg::portMask_t   timesUp;
  routerArbPkg::grantState_t state;

  always_comb
  begin
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      req[p] = ports[p].req;
    end
  end

  // the timers and the grant machine feed each other every cycle.
  portTimerBank uTimers (
    .clk      (clk),
    .rst      (rst),
    .ports    (ports),
    .runTimer (runTimer),
    .timesUp  (timesUp)
  );

  grantFsm uGrantFsm (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .timesUp  (timesUp),
    .state    (state),
    .runTimer (runTimer)
  );

  flitSwitch uSwitch (
    .clk      (clk),
    .rst      (rst),
    .state    (state),
    .ports    (ports),
    .grant    (grant),
    .outValid (outValid),
    .outFlit  (outFlit)
  );

endmodule

`default_nettype wire

//--- hw/portTimerBank.sv
`timescale 1ns/1ps
`default_nettype none
`include "routerArb_macros.svh"

module portTimerBank (
  input  wire logic                                      clk,
  input  wire logic                                      rst,
  input  wire routerArbPkg::portIn_t [`NUM_PORTS-1:0]    ports,
  input  wire routerArbPkg::portMask_t                   runTimer,
  output routerArbPkg::portMask_t                        timesUp
);

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : genTimer
    routerArbPkg::pktLen_t limit;
    routerArbPkg::pktLen_t count;
    logic                  headFlit;

    assign headFlit = (ports[p].flitId == routerArbPkg::flitId_t'(`HEAD_FLIT_ID));

    always_ff @(posedge clk)
    begin
      if (rst)
      begin
        limit <= '0;
        count <= '0;
      end
      else
      begin
        if (headFlit)
          limit <= ports[p].length; // a new packet sets the hold limit.

        // the count restarts from zero every time a hold begins.
        if (runTimer[p])
          count <= count + 1'b1;
        else
          count <= '0;
      end
    end

    // with limit L the match ends a hold of L+1 cycles.
    assign timesUp[p] = (count == limit);
  end

endmodule

`default_nettype wire

//--- hw/routerArbPkg.sv
`default_nettype none
`include "routerArb_macros.svh"

package routerArbPkg;

  // port index 0 is Local, then North, East, West and South in that order.

  typedef logic [`FLIT_ID_W-1:0] flitId_t;
  typedef logic [`LEN_W-1:0]     pktLen_t;
  typedef logic [`PAYLOAD_W-1:0] payload_t;

  typedef logic [`NUM_PORTS-1:0] portMask_t; // one bit per input port.

  typedef struct packed {
    logic     req;
    flitId_t  flitId;
    pktLen_t  length;  // the hold limit is taken from head flits only.
    payload_t payload;
  } portIn_t;

  typedef struct packed {
    flitId_t  flitId;
    payload_t payload;
  } flitOut_t;

  // bit 0 marks idle, bit p+1 marks a grant to port p.
  typedef enum logic [`NUM_PORTS:0] {
    IDLE    = 6'b000001,
    GRANT_L = 6'b000010,
    GRANT_N = 6'b000100,
    GRANT_E = 6'b001000,
    GRANT_W = 6'b010000,
    GRANT_S = 6'b100000
  } grantState_t;

endpackage

`default_nettype wire

//--- hw/routerArb_macros.svh
`ifndef ROUTER_ARB_MACROS_SVH
`define ROUTER_ARB_MACROS_SVH

// the allocator serves the Local, North, East, West and South input ports.
`define NUM_PORTS 5

`define FLIT_ID_W 3
`define LEN_W 12 // the packet length also sets the width of the hold counters.
`define PAYLOAD_W 32

// a flit with this identifier starts a packet and carries its length.
`define HEAD_FLIT_ID 1

`endif

//--- project.f
+incdir+hw
hw/routerArbPkg.sv
hw/portTimerBank.sv
hw/grantFsm.sv
hw/flitSwitch.sv
hw/outPortAllocator.sv
tb/outPortAllocator_chk.sv
tb/outPortAllocatorTb.sv

//--- tb/outPortAllocatorTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "routerArb_macros.svh"

module outPortAllocatorTb;

  typedef routerArbPkg::portIn_t [`NUM_PORTS-1:0] portBus_t;
  typedef routerArbPkg::pktLen_t [`NUM_PORTS-1:0] lenBus_t;

  typedef struct packed {
    routerArbPkg::portMask_t reqMask;
    routerArbPkg::portMask_t headMask; // ports that present a head flit.
    lenBus_t                 len;
    logic [7:0]              cycles;
  } stimRow_t;

  localparam int          NUM_ROWS     = 9;
  localparam int          IDLE_TIMEOUT = 20;
  localparam logic [15:0] LFSR_SEED    = 16'd31620;

  logic                    clk;
  logic                    rst;
  portBus_t                ports;
  routerArbPkg::portMask_t grant;
  logic                    outValid;
  routerArbPkg::flitOut_t  outFlit;

  stimRow_t    rows [NUM_ROWS];
  logic [15:0] lfsrState;

  // the reference model keeps holder at -1 while no port holds the output.
  int                      holder;
  routerArbPkg::pktLen_t   limits [`NUM_PORTS];
  routerArbPkg::pktLen_t   counts [`NUM_PORTS];
  routerArbPkg::portMask_t expGrant;
  logic                    expValid;
  routerArbPkg::flitOut_t  expFlit;
  logic                    flitKnown;

  int grantErrors;
  int validErrors;
  int flitErrors;
  int timeouts;

  outPortAllocator UUT (
    .clk      (clk),
    .rst      (rst),
    .ports    (ports),
    .grant    (grant),
    .outValid (outValid),
    .outFlit  (outFlit)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v         = {v[30:0], lfsrState[0]};
      lfsrState = lfsrNext(lfsrState);
    end
    return v;
  endfunction

  function automatic stimRow_t makeRow(input routerArbPkg::portMask_t req,
                                       input routerArbPkg::portMask_t head,
                                       input int l0, input int l1, input int l2,
                                       input int l3, input int l4, input int cycles);
    stimRow_t row;
    row.reqMask  = req;
    row.headMask = head;
    row.len[0]   = routerArbPkg::pktLen_t'(l0);
    row.len[1]   = routerArbPkg::pktLen_t'(l1);
    row.len[2]   = routerArbPkg::pktLen_t'(l2);
    row.len[3]   = routerArbPkg::pktLen_t'(l3);
    row.len[4]   = routerArbPkg::pktLen_t'(l4);
    row.cycles   = 8'(cycles);
    return row;
  endfunction

  // bit 0 of every mask is Local, bit 4 is South.
  task automatic loadTable();
    rows[0] = makeRow(5'b00000, 5'b00000, 0, 0, 0, 0, 0, 3);
    rows[1] = makeRow(5'b11111, 5'b11111, 3, 1, 0, 2, 4, 20);
    rows[2] = makeRow(5'b11111, 5'b00000, 9, 9, 9, 9, 9, 14); // without head flits the old limits stay.
    rows[3] = makeRow(5'b00101, 5'b00000, 7, 7, 7, 7, 7, 10);
    rows[4] = makeRow(5'b00000, 5'b00000, 0, 0, 0, 0, 0, 3);
    rows[5] = makeRow(5'b10010, 5'b10010, 0, 6, 0, 0, 5, 4);
    rows[6] = makeRow(5'b10000, 5'b00000, 0, 0, 0, 0, 0, 4);
    rows[7] = makeRow(5'b01000, 5'b01000, 0, 0, 0, 0, 0, 5);
    rows[8] = makeRow(5'b00000, 5'b00000, 0, 0, 0, 0, 0, 2);
  endtask

  function automatic portBus_t buildPorts(input stimRow_t row);
    portBus_t bus;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      bus[p].req    = row.reqMask[p];
      bus[p].length = row.len[p];
      if (row.headMask[p])
        bus[p].flitId = routerArbPkg::flitId_t'(`HEAD_FLIT_ID);
      else
        bus[p].flitId = routerArbPkg::flitId_t'(2 + takeBits(2)); // body ids 2 to 5.
      bus[p].payload = routerArbPkg::payload_t'(takeBits(`PAYLOAD_W));
    end
    return bus;
  endfunction

  task automatic resetModel();
    holder    = -1;
    expGrant  = '0;
    expValid  = 1'b0;
    flitKnown = 1'b0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      limits[p] = '0;
      counts[p] = '0;
    end
  endtask

  // advance the model by one clock edge with the inputs sampled at that edge.
  task automatic stepModel();
    routerArbPkg::portMask_t reqNow;
    routerArbPkg::portMask_t expired;
    routerArbPkg::portMask_t run;
    int                      nextHolder;
    int                      start;
    int                      idx;
    run = '0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      reqNow[p]  = ports[p].req;
      expired[p] = (counts[p] == limits[p]);
    end
    expGrant = '0;
    expValid = 1'b0;
    if (holder >= 0)
    begin
      expGrant[holder] = 1'b1;
      expValid         = reqNow[holder];
      expFlit          = '{flitId: ports[holder].flitId, payload: ports[holder].payload};
      flitKnown        = 1'b1;
    end
    if ((holder >= 0) && reqNow[holder] && !expired[holder])
    begin
      run[holder] = 1'b1;
      nextHolder  = holder;
    end
    else
    begin
      nextHolder = -1;
      start      = (holder < 0) ? 0 : holder + 1; // idle scans from Local.
      for (int k = 0; k < `NUM_PORTS; k++)
      begin
        idx = (start + k) % `NUM_PORTS;
        if ((nextHolder < 0) && reqNow[idx])
          nextHolder = idx;
      end
    end
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (ports[p].flitId == routerArbPkg::flitId_t'(`HEAD_FLIT_ID))
        limits[p] = ports[p].length;
      counts[p] = run[p] ? counts[p] + 1'b1 : '0;
    end
    holder = nextHolder;
  endtask

  task automatic checkGrant(input routerArbPkg::portMask_t got,
                            input routerArbPkg::portMask_t exp);
    if (got !== exp)
    begin
      grantErrors++;
      $display("** Error at %0t ns: grant is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic checkValid(input logic got, input logic exp);
    if (got !== exp)
    begin
      validErrors++;
      $display("** Error at %0t ns: outValid is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic checkFlit(input routerArbPkg::flitOut_t got,
                           input routerArbPkg::flitOut_t exp);
    if (got !== exp)
    begin
      flitErrors++;
      $display("** Error at %0t ns: outFlit is id %0d payload %h, expected id %0d payload %h",
               $time, got.flitId, got.payload, exp.flitId, exp.payload);
    end
  endtask

  task automatic checkOutputs();
    checkGrant(grant, expGrant);
    checkValid(outValid, expValid);
    if (flitKnown)
      checkFlit(outFlit, expFlit); // outFlit is undefined until the first grant.
  endtask

  task automatic driveCycle(input portBus_t nextPorts);
    @(posedge clk);
    stepModel();
    ports <= nextPorts;
    @(negedge clk);
    checkOutputs();
  endtask

  task automatic waitGrantIdle(output bit reached);
    int waited;
    reached = 1'b0;
    waited  = 0;
    while (!reached && (waited < IDLE_TIMEOUT))
    begin
      driveCycle('0);
      waited++;
      reached = (grant == '0);
    end
  endtask

  initial
  begin
    bit idleSeen;
    rst         = 1'b1;
    ports       = '0;
    lfsrState   = LFSR_SEED;
    grantErrors = 0;
    validErrors = 0;
    flitErrors  = 0;
    timeouts    = 0;
    loadTable();
    resetModel();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    checkOutputs();
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      for (int c = 0; c < rows[r].cycles; c++)
        driveCycle(buildPorts(rows[r]));
    end
    waitGrantIdle(idleSeen);
    if (!idleSeen)
    begin
      timeouts++;
      $display("the grant did not return to zero after all requests were dropped");
    end
    $display("errors: grant %0d, valid %0d, flit %0d, timeouts %0d",
             grantErrors, validErrors, flitErrors, timeouts);
    if ((grantErrors + validErrors + flitErrors + timeouts) == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/outPortAllocator_chk.sv
`timescale 1ns/1ps
`default_nettype none
`include "routerArb_macros.svh"

module outPortAllocatorChk (
  input wire logic                    clk,
  input wire logic                    rst,
  input wire routerArbPkg::portMask_t grant,
  input wire routerArbPkg::portMask_t runTimer,
  input wire logic                    outValid
);

  // the output belongs to one port at a time.
  grantOneHot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(grant)
  )
  else $error("grant has more than one bit set");

  // only the holder may run its timer.
  singleTimer: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(runTimer)
  )
  else $error("more than one runTimer bit is set");

  validNeedsGrant: assert property (
    @(posedge clk) disable iff (rst)
    outValid |-> (grant != '0)
  )
  else $error("outValid is high while no port is granted");

endmodule

// the checker also watches the runTimer mask inside the allocator.
bind outPortAllocator outPortAllocatorChk uChk (
  .clk      (clk),
  .rst      (rst),
  .grant    (grant),
  .runTimer (runTimer),
  .outValid (outValid)
);

`default_nettype wire
